/* logic/rsBlockCounter.sv */
//------------------------------------------------------------
// codeword position counter, started by startPls
// also flags the message phase for the parity register
//------------------------------------------------------------

module rsBlockCounter #(
   parameter int codeLength    = 255,
   parameter int messageLength = 233
) (
   input  logic              CLK,
   input  logic              RESET,
   input  logic              enable,
   input  logic              startPls,
   output rsCodePkg::countT  count,
   output logic              messagePhase
);

   // count still reaches codeLength so the last parity gets selected
   localparam rsCodePkg::countT endCount   = rsCodePkg::countT'(codeLength);
   localparam rsCodePkg::countT messageEnd = rsCodePkg::countT'(messageLength);

   rsCodePkg::countT countReg;

   //------------------------------------------------------------
   // position counter
   //------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         countReg <= '0;
      end
      else if (enable) begin
         if (startPls) begin
            countReg <= rsCodePkg::countT'(1);    // symbol 0 is in this cycle
         end
         else if ((countReg == '0) || (countReg == endCount)) begin
            countReg <= '0;                       // idle between blocks
         end
         else begin
            countReg <= countReg + rsCodePkg::countT'(1);
         end
      end
   end

   // symbol 0 has to enter the divider in the start cycle itself
   always_comb begin
      messagePhase = startPls || (countReg < messageEnd);
   end

   assign count = countReg;

endmodule

/* logic/rsCodePkg.sv */
//------------------------------------------------------------
// RS code geometry, block position type and the generator
// polynomial coefficients, worked out at elaboration
//------------------------------------------------------------

package rsCodePkg;

   localparam int defaultCodeLength    = 255;   // symbols per codeword
   localparam int defaultMessageLength = 233;   // message symbols per codeword

   // exponent of the first generator root alpha^firstRoot
   localparam int firstRoot = 0;

   // enough room for any degree a GF(2^8) code can have
   localparam int maxDegree = 255;

   // position in the codeword, runs up to 255
   typedef logic [7:0] countT;

   //------------------------------------------------------------
   // coefficient of x^index in
   //   g(x) = prod_{j=0}^{parityCount-1} (x + alpha^(firstRoot+j))
   //------------------------------------------------------------
   function automatic rsFieldPkg::symbolT genCoeff(int index, int parityCount);
      rsFieldPkg::symbolT poly [0:maxDegree];
      rsFieldPkg::symbolT root;
      for (int k = 0; k <= maxDegree; k++) begin
         poly[k] = '0;
      end
      poly[0] = rsFieldPkg::symbolT'(1);       // start from g(x) = 1

      for (int j = 0; j < parityCount; j++) begin
         root = rsFieldPkg::gfAlphaPow(firstRoot + j);
         // multiply by (x + root), top down so poly[k-1] is still old
         for (int k = j + 1; k > 0; k--) begin
            poly[k] = poly[k-1] ^ rsFieldPkg::gfMul(poly[k], root);
         end
         poly[0] = rsFieldPkg::gfMul(poly[0], root);
      end

      return poly[index];
   endfunction

endpackage

/* logic/rsEncodeTop.sv */
//------------------------------------------------------------
// systematic RS encoder over GF(2^8), one symbol per enable
// message passes through, parity follows in the same stream
//------------------------------------------------------------

module rsEncodeTop #(
   parameter int codeLength    = rsCodePkg::defaultCodeLength,
   parameter int messageLength = rsCodePkg::defaultMessageLength
) (
   input  logic                CLK,
   input  logic                RESET,
   input  logic                enable,       // clock enable for all block state
   input  logic                startPls,     // marks message symbol 0
   input  rsFieldPkg::symbolT  dataIn,
   output rsFieldPkg::symbolT  dataOut
);

   localparam int parityCount = codeLength - messageLength;

   rsCodePkg::countT    count;
   logic                messagePhase;
   rsFieldPkg::symbolT  parityHead;

   //------------------------------------------------------------
   // block position
   //------------------------------------------------------------
   rsBlockCounter #(
      .codeLength    (codeLength),
      .messageLength (messageLength)
   ) i_blockCounter (
      .CLK          (CLK),
      .RESET        (RESET),
      .enable       (enable),
      .startPls     (startPls),
      .count        (count),
      .messagePhase (messagePhase)
   );

   //------------------------------------------------------------
   // parity generation
   //------------------------------------------------------------
   rsParityLfsr #(
      .parityCount (parityCount)
   ) i_parityLfsr (
      .CLK          (CLK),
      .RESET        (RESET),
      .enable       (enable),
      .startPls     (startPls),
      .messagePhase (messagePhase),
      .dataIn       (dataIn),
      .parityHead   (parityHead)
   );

   // message and parity merge
   rsOutputStage #(
      .messageLength (messageLength)
   ) i_outputStage (
      .CLK        (CLK),
      .RESET      (RESET),
      .enable     (enable),
      .count      (count),
      .dataIn     (dataIn),
      .parityHead (parityHead),
      .dataOut    (dataOut)
   );

endmodule

/* logic/rsFieldPkg.sv */
//------------------------------------------------------------
// GF(2^8) symbol type and field arithmetic for the RS encoder
// all functions are constant, so parameters may call them
//------------------------------------------------------------

package rsFieldPkg;

   localparam int symbolWidth = 8;          // bits per code symbol

   typedef logic [symbolWidth-1:0] symbolT;

   // x^8 + x^4 + x^3 + x^2 + 1
   localparam logic [symbolWidth:0] fieldPoly = 9'h11d;

   // number of nonzero field elements
   localparam int fieldOrder = (1 << symbolWidth) - 1;

   //------------------------------------------------------------
   // multiply by x, reduced by the field polynomial
   //------------------------------------------------------------
   function automatic symbolT gfMulX(symbolT a);
      symbolT shifted;
      shifted = a << 1;
      if (a[symbolWidth-1]) begin
         shifted = shifted ^ fieldPoly[symbolWidth-1:0];
      end
      return shifted;
   endfunction

   //------------------------------------------------------------
   // general multiply, shift and add over the bits of b
   //------------------------------------------------------------
   function automatic symbolT gfMul(symbolT a, symbolT b);
      symbolT prod;
      symbolT partial;
      prod    = '0;
      partial = a;
      for (int k = 0; k < symbolWidth; k++) begin
         if (b[k]) begin
            prod = prod ^ partial;
         end
         partial = gfMulX(partial);            // a * x^(k+1)
      end
      return prod;
   endfunction

   //------------------------------------------------------------
   // alpha^power, alpha being the root x of fieldPoly
   //------------------------------------------------------------
   function automatic symbolT gfAlphaPow(int power);
      int     exponent;
      symbolT acc;
      exponent = power % fieldOrder;
      if (exponent < 0) begin
         exponent = exponent + fieldOrder;     // negative powers wrap
      end
      acc = symbolT'(1);
      for (int k = 0; k < exponent; k++) begin
         acc = gfMulX(acc);
      end
      return acc;
   endfunction

endpackage

/* logic/rsOutputStage.sv */
//------------------------------------------------------------
// output path, aligns message and parity symbols and picks
// one of them by codeword position, two cycles of latency
//------------------------------------------------------------

module rsOutputStage #(
   parameter int messageLength = 233
) (
   input  logic                CLK,
   input  logic                RESET,
   input  logic                enable,
   input  rsCodePkg::countT    count,
   input  rsFieldPkg::symbolT  dataIn,
   input  rsFieldPkg::symbolT  parityHead,
   output rsFieldPkg::symbolT  dataOut
);

   localparam rsCodePkg::countT messageEnd = rsCodePkg::countT'(messageLength);

   rsFieldPkg::symbolT dataReg;      // message symbol, one cycle late
   rsFieldPkg::symbolT parityFF;     // parity head, one cycle late
   rsFieldPkg::symbolT selected;
   rsFieldPkg::symbolT dataOutReg;

   //------------------------------------------------------------
   // first stage
   //------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         dataReg  <= '0;
         parityFF <= '0;
      end
      else if (enable) begin
         dataReg  <= dataIn;
         parityFF <= parityHead;
      end
   end

   // count already points one past the symbol held in dataReg
   always_comb begin
      if (count <= messageEnd) begin
         selected = dataReg;
      end
      else begin
         selected = parityFF;
      end
   end

   //------------------------------------------------------------
   // second stage, free running
   //------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         dataOutReg <= '0;
      end
      else begin
         dataOutReg <= selected;
      end
   end

   assign dataOut = dataOutReg;

endmodule

/* logic/rsParityLfsr.sv */
//------------------------------------------------------------
// parity shift register, divides the message by g(x)
// the remainder left after the message phase is the parity
//------------------------------------------------------------

module rsParityLfsr #(
   parameter int parityCount = 22
) (
   input  logic                CLK,
   input  logic                RESET,
   input  logic                enable,
   input  logic                startPls,
   input  logic                messagePhase,
   input  rsFieldPkg::symbolT  dataIn,
   output rsFieldPkg::symbolT  parityHead
);

   rsFieldPkg::symbolT feedback;
   rsFieldPkg::symbolT parityReg [parityCount];
   rsFieldPkg::symbolT product   [parityCount];

   //------------------------------------------------------------
   // feedback term
   //------------------------------------------------------------
   always_comb begin
      if (startPls) begin
         feedback = dataIn;                       // old remainder is dropped
      end
      else if (messagePhase) begin
         feedback = dataIn ^ parityHead;
      end
      else begin
         feedback = '0;                           // plain shift, parity goes out
      end
   end

   //------------------------------------------------------------
   // one stage per generator coefficient
   //------------------------------------------------------------
   for (genvar i = 0; i < parityCount; i++) begin : gStage
      localparam rsFieldPkg::symbolT coeff = rsCodePkg::genCoeff(i, parityCount);

      // constant multiplier, reduces to an xor network
      assign product[i] = rsFieldPkg::gfMul(feedback, coeff);

      always_ff @(posedge CLK or negedge RESET) begin
         if (!RESET) begin
            parityReg[i] <= '0;
         end
         else if (enable) begin
            if (i == 0) begin
               parityReg[i] <= product[i];
            end
            else if (startPls) begin
               parityReg[i] <= product[i];
            end
            else begin
               parityReg[i] <= parityReg[(i == 0) ? 0 : i-1] ^ product[i];
            end
         end
      end
   end

   // highest degree term, first parity symbol out
   assign parityHead = parityReg[parityCount-1];

endmodule

/* project.f */
logic/rsFieldPkg.sv
logic/rsCodePkg.sv
logic/rsBlockCounter.sv
logic/rsParityLfsr.sv
logic/rsOutputStage.sv
logic/rsEncodeTop.sv
verif/rsEncodeTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the RS encoder testbench with Verilator and runs it
# pass or fail is taken from the simulation log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
SIM_EXE=rsEncodeSim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
   --top-module rsEncodeTb \
   --Mdir "$BUILD_DIR" -o "$SIM_EXE" \
   -f project.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
fi

grep -qx "NO ERRORS" "$LOG_FILE"
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation FAILED, see $LOG_FILE"
   exit 1
fi

echo "simulation passed"
exit 0

/* verif/rsEncodeTb.sv */
//------------------------------------------------------------
// testbench for the RS encoder that runs every line of the test
// data file and checks passthrough, syndromes and gap tolerance
//------------------------------------------------------------

module rsEncodeTb;

   localparam int codeLength    = rsCodePkg::defaultCodeLength;
   localparam int messageLength = rsCodePkg::defaultMessageLength;
   localparam int parityCount   = codeLength - messageLength;
   localparam int resetCycles   = 8;
   localparam int idleCycles    = 4;      // enabled cycles before the first start
   localparam int flushCycles   = 3;      // drains the two output stages
   localparam logic [31:0] baseSeed = 32'h135b_3663;
   localparam string dataFile = "verif/rsEncodeTestdata.txt";

   logic               CLK;
   logic               RESET;
   logic               enable;
   logic               startPls;
   rsFieldPkg::symbolT dataIn;
   rsFieldPkg::symbolT dataOut;

   // test table with one entry per data file line
   string       testName   [$];
   logic [31:0] testSeed   [$];
   int          testGap    [$];
   int          testBlocks [$];
   bit          loaded;

   rsFieldPkg::symbolT sentSym [$];             // presented symbols including parity slots
   rsFieldPkg::symbolT gotSym  [$];             // symbols collected from dataOut
   rsFieldPkg::symbolT refParity [bit [47:0]];  // first parity seen per seed and block

   rsEncodeTop i_dut (
      .CLK      (CLK),
      .RESET    (RESET),
      .enable   (enable),
      .startPls (startPls),
      .dataIn   (dataIn),
      .dataOut  (dataOut)
   );

   always begin
      #4 CLK = ~CLK;
   end

   //------------------------------------------------------------
   // reference arithmetic
   //------------------------------------------------------------
   function automatic logic [31:0] lcgNext(logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // full 15-bit product before the reduction
   function automatic rsFieldPkg::symbolT fieldMul(rsFieldPkg::symbolT a, rsFieldPkg::symbolT b);
      logic [15:0] wide;
      wide = '0;
      for (int k = 0; k < 8; k++) begin
         if (b[k]) begin
            wide = wide ^ (16'(a) << k);
         end
      end
      for (int k = 15; k >= 8; k--) begin
         if (wide[k]) begin
            wide = wide ^ (16'(rsFieldPkg::fieldPoly) << (k - 8));
         end
      end
      return wide[7:0];
   endfunction

   function automatic rsFieldPkg::symbolT alphaPower(int power);
      rsFieldPkg::symbolT acc;
      acc = 8'h01;
      for (int k = 0; k < power; k++) begin
         acc = fieldMul(acc, 8'h02);
      end
      return acc;
   endfunction

   // Horner over one collected codeword with symbol 0 as top degree
   function automatic rsFieldPkg::symbolT evalCodeword(int first, rsFieldPkg::symbolT x);
      rsFieldPkg::symbolT acc;
      acc = '0;
      for (int n = 0; n < codeLength; n++) begin
         acc = fieldMul(acc, x) ^ gotSym[first + n];
      end
      return acc;
   endfunction

   task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abortRun(string reason);
      $display("%s", reason);
      $display("ERRORS FOUND");
      $fatal(1, "test setup failed");
   endtask

   //------------------------------------------------------------
   // test data file
   //------------------------------------------------------------
   task automatic readTests();
      int          fd;
      int          fields;
      string       line;
      string       name;
      logic [31:0] seed;
      int          gap;
      int          blocks;
      fd = $fopen(dataFile, "r");
      if (fd == 0) begin
         abortRun({"cannot open the test data file ", dataFile});
      end
      else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
               if ((line.len() > 1) && (line.getc(0) != "#")) begin
                  fields = $sscanf(line, "%s %h %d %d", name, seed, gap, blocks);
                  if ((fields != 4) || (gap < 0) || (gap > 90) || (blocks < 1)) begin
                     abortRun({"malformed line in the test data file: ", line});
                  end
                  testName.push_back(name);
                  testSeed.push_back(seed);
                  testGap.push_back(gap);
                  testBlocks.push_back(blocks);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   //------------------------------------------------------------
   // one test line runs reset, all blocks and the checks
   //------------------------------------------------------------
   task automatic runTest(string name, logic [31:0] seed, int gapRate, int blocks);
      logic [31:0]        msgState;
      logic [31:0]        gapState;
      int                 total;
      int                 symIdx;
      int                 idleLeft;
      int                 flushLeft;
      int                 first;
      bit [1:0]           presHist;   // [1] is two cycles back
      bit                 presented;
      bit                 gap;
      bit [47:0]          key;
      rsFieldPkg::symbolT root;
      sentSym.delete();
      gotSym.delete();
      msgState  = baseSeed ^ seed;
      gapState  = lcgNext(baseSeed) ^ seed;    // gaps never disturb the message stream
      total     = blocks * codeLength;
      symIdx    = 0;
      idleLeft  = idleCycles;
      flushLeft = flushCycles;
      presHist  = 2'b00;

      RESET    = 1'b0;
      enable   = 1'b0;
      startPls = 1'b0;
      dataIn   = '0;
      repeat (resetCycles) begin
         @(posedge CLK);
         #1;
         checkValue({name, " in reset"}, 32'd0, 32'(dataOut));
      end
      RESET = 1'b1;

      while (flushLeft > 0) begin
         @(posedge CLK);
         #1;
         if (presHist[1]) begin
            gotSym.push_back(dataOut);             // new symbol this cycle
         end
         else if (gotSym.size() == 0) begin
            checkValue({name, " before first symbol"}, 32'd0, 32'(dataOut));
         end
         presented = 1'b0;
         if (idleLeft > 0) begin
            enable   = 1'b1;
            startPls = 1'b0;
            dataIn   = '0;
            idleLeft--;
         end
         else if (symIdx < total) begin
            gapState = lcgNext(gapState);
            gap = (gapRate > 0) && ((int'(gapState[30:16]) % 100) < gapRate);
            if (gap) begin
               enable   = 1'b0;
               startPls = 1'b0;
               dataIn   = gapState[15:8];          // junk that must not be taken
            end
            else begin
               enable   = 1'b1;
               startPls = ((symIdx % codeLength) == 0);
               if (((symIdx % codeLength) < messageLength) && (seed != 0)) begin
                  msgState = lcgNext(msgState);
                  dataIn   = msgState[23:16];
               end
               else begin
                  dataIn = '0;                     // zero message or parity slot
               end
               sentSym.push_back(dataIn);
               symIdx++;
               presented = 1'b1;
            end
         end
         else begin
            enable   = 1'b1;
            startPls = 1'b0;
            dataIn   = '0;
            flushLeft--;
         end
         presHist = {presHist[0], presented};
      end

      for (int b = 0; b < blocks; b++) begin
         first = b * codeLength;
         for (int n = 0; n < messageLength; n++) begin
            checkValue($sformatf("%s block %0d message %0d", name, b, n),
                       32'(sentSym[first + n]), 32'(gotSym[first + n]));
         end
         // every generator root has to be a root of the codeword
         for (int i = 0; i < parityCount; i++) begin
            root = alphaPower(i);
            checkValue($sformatf("%s block %0d syndrome %0d", name, b, i),
                       32'd0, 32'(evalCodeword(first, root)));
         end
         for (int n = messageLength; n < codeLength; n++) begin
            key = {seed, 8'(b), 8'(n)};
            if (seed == 0) begin
               checkValue($sformatf("%s block %0d zero parity %0d", name, b, n),
                          32'd0, 32'(gotSym[first + n]));
            end
            if (refParity.exists(key)) begin
               checkValue($sformatf("%s block %0d same parity %0d", name, b, n),
                          32'(refParity[key]), 32'(gotSym[first + n]));
            end
            else begin
               refParity[key] = gotSym[first + n];
            end
         end
      end
      $display("test %s passed %0d blocks", name, blocks);
   endtask

   //------------------------------------------------------------
   // main sequence and watchdog
   //------------------------------------------------------------
   initial begin
      CLK      = 1'b0;
      RESET    = 1'b0;
      enable   = 1'b0;
      startPls = 1'b0;
      dataIn   = '0;
      readTests();
      if (testName.size() == 0) begin
         abortRun("the test data file holds no tests");
      end
      loaded = 1'b1;
      foreach (testName[k]) begin
         runTest(testName[k], testSeed[k], testGap[k], testBlocks[k]);
      end
      $display("NO ERRORS");
      $finish;
   end

   initial begin : watchdog
      int limit;
      wait (loaded);
      limit = 0;
      foreach (testName[k]) begin
         limit += resetCycles + idleCycles + flushCycles + 20;
         limit += testBlocks[k] * 300 * 100 / (100 - testGap[k]);   // gaps stretch blocks
      end
      repeat (limit) @(posedge CLK);
      $display("timeout, the tests did not finish within %0d cycles", limit);
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

endmodule

/* verif/rsEncodeTestdata.txt */
# RS encoder tests, one per line, read in order
# columns: name  seed (hex)  enable gap percent (0..90)  block count
# seed 0 sends all-zero messages, whose parity must be zero too
# a repeated seed must give the same parity as its first run
singleBlock        0000a5c3   0    1
singleGaps         0000a5c3   20   1
heavyGaps          0000a5c3   45   1
backToBack         00007e11   0    3
backToBackGaps     00007e11   15   3
zeroMessage        00000000   0    2
zeroMessageGaps    00000000   30   1
longRun            3c9f0d21   0    4
longRunGaps        3c9f0d21   10   4
sparseGaps         00005151   5    2
sparseGapsAgain    00005151   60   2
highSeed           f00dcafe   0    1
highSeedGaps       f00dcafe   25   1
mixedZeroFirst     00000000   50   1
lastBlocks         9e3779b9   0    2
lastBlocksGaps     9e3779b9   35   2
